// File: common/lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;      // n, z, p
    typedef logic [3:0]  lc3b_imm4;     // shift amount

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // zero encodings are the no-op defaults of the control rom
    typedef enum logic [2:0] {
        lc3b_alu_op_pass,
        lc3b_alu_op_add,
        lc3b_alu_op_and,
        lc3b_alu_op_not,
        lc3b_alu_op_sll,
        lc3b_alu_op_srl,
        lc3b_alu_op_sra
    } lc3b_alu_op;

    typedef enum logic [1:0] {
        lc3b_alu_mux_sel_sr2,
        lc3b_alu_mux_sel_imm5,
        lc3b_alu_mux_sel_imm4       // shf only
    } lc3b_alu_mux_sel;

    typedef enum logic [1:0] {
        lc3b_pc_mux_sel_pc_plus2,
        lc3b_pc_mux_sel_pcn,        // pc-relative target
        lc3b_pc_mux_sel_alu         // register target
    } lc3b_pc_mux_sel;

    typedef enum logic {
        lc3b_pc_adder_mux_sel_offset9,
        lc3b_pc_adder_mux_sel_offset11
    } lc3b_pc_adder_mux_sel;

    typedef enum logic [1:0] {
        lc3b_regfile_data_mux_sel_alu,
        lc3b_regfile_data_mux_sel_pcn,
        lc3b_regfile_data_mux_sel_pc    // link value
    } lc3b_regfile_data_mux_sel;

    typedef enum logic {
        lc3b_cc_gen_mux_sel_alu,
        lc3b_cc_gen_mux_sel_pcn
    } lc3b_cc_gen_mux_sel;

    typedef enum logic {
        lc3b_regfile_dest_mux_sel_dest,
        lc3b_regfile_dest_mux_sel_r7
    } lc3b_regfile_dest_mux_sel;

    localparam lc3b_reg  link_reg = 3'd7;
    localparam lc3b_word reset_pc = 16'h0000;

endpackage

`default_nettype wire

// File: execute/alu.sv
`default_nettype none

module alu (
    input  wire lc3b_pkg::lc3b_alu_op op,
    input  wire lc3b_pkg::lc3b_word   a,
    input  wire lc3b_pkg::lc3b_word   b,
    output lc3b_pkg::lc3b_word        result
);
    import lc3b_pkg::*;

    lc3b_imm4 shamt;

    assign shamt = b[3:0];                      // shifts use the low nibble

    always_comb begin
        case (op)
            lc3b_alu_op_add: result = a + b;
            lc3b_alu_op_and: result = a & b;
            lc3b_alu_op_not: result = ~a;
            lc3b_alu_op_sll: result = a << shamt;
            lc3b_alu_op_srl: result = a >> shamt;
            lc3b_alu_op_sra: result = $signed(a) >>> shamt;
            default:         result = a;        // pass, for jmp/jsrr
        endcase
    end

endmodule

`default_nettype wire

// File: decode/control_rom.sv
`default_nettype none

module control_rom (
    input  wire lc3b_pkg::lc3b_word                ir_in,
    output lc3b_pkg::lc3b_reg                      regfile_sr1,
    output lc3b_pkg::lc3b_reg                      regfile_sr2,
    output lc3b_pkg::lc3b_alu_mux_sel              alu_mux_sel,
    output lc3b_pkg::lc3b_alu_op                   alu_op,
    output lc3b_pkg::lc3b_pc_mux_sel               pc_mux_sel,
    output lc3b_pkg::lc3b_pc_adder_mux_sel         pc_adder_mux_sel,
    output logic                                   conditional_branch,
    output logic                                   cc_load,
    output lc3b_pkg::lc3b_cc_gen_mux_sel           cc_gen_mux_sel,
    output lc3b_pkg::lc3b_regfile_data_mux_sel     regfile_data_mux_sel,
    output lc3b_pkg::lc3b_regfile_dest_mux_sel     regfile_dest_mux_sel,
    output logic                                   regfile_load
);
    import lc3b_pkg::*;

    lc3b_opcode opcode;
    lc3b_reg    sr1;
    lc3b_reg    sr2;

    assign opcode = lc3b_opcode'(ir_in[15:12]);
    assign sr1    = ir_in[8:6];
    assign sr2    = ir_in[2:0];

    always_comb begin
        regfile_sr1          = 3'd0;
        regfile_sr2          = 3'd0;
        alu_mux_sel          = lc3b_alu_mux_sel_sr2;
        alu_op               = lc3b_alu_op_pass;
        pc_mux_sel           = lc3b_pc_mux_sel_pc_plus2;
        pc_adder_mux_sel     = lc3b_pc_adder_mux_sel_offset9;
        conditional_branch   = 1'b0;
        cc_load              = 1'b0;
        cc_gen_mux_sel       = lc3b_cc_gen_mux_sel_alu;
        regfile_data_mux_sel = lc3b_regfile_data_mux_sel_alu;
        regfile_dest_mux_sel = lc3b_regfile_dest_mux_sel_dest;
        regfile_load         = 1'b0;

        case (opcode)
            op_add, op_and: begin
                regfile_sr1 = sr1;
                regfile_sr2 = sr2;
                if (ir_in[5])
                    alu_mux_sel = lc3b_alu_mux_sel_imm5;  // immediate form
                if (opcode == op_add)
                    alu_op = lc3b_alu_op_add;
                else
                    alu_op = lc3b_alu_op_and;
                cc_load      = 1'b1;
                regfile_load = 1'b1;
            end

            op_not: begin
                regfile_sr1  = sr1;
                alu_op       = lc3b_alu_op_not;
                cc_load      = 1'b1;
                regfile_load = 1'b1;
            end

            op_shf: begin
                regfile_sr1 = sr1;
                alu_mux_sel = lc3b_alu_mux_sel_imm4;
                if (!ir_in[4])
                    alu_op = lc3b_alu_op_sll;
                else if (!ir_in[5])
                    alu_op = lc3b_alu_op_srl;             // logical
                else
                    alu_op = lc3b_alu_op_sra;             // arithmetic
                cc_load      = 1'b1;
                regfile_load = 1'b1;
            end

            op_lea: begin
                cc_load              = 1'b1;
                cc_gen_mux_sel       = lc3b_cc_gen_mux_sel_pcn;
                regfile_data_mux_sel = lc3b_regfile_data_mux_sel_pcn;
                regfile_load         = 1'b1;
            end

            op_br: begin
                conditional_branch = 1'b1;                // taken on nzp & cc
                pc_mux_sel         = lc3b_pc_mux_sel_pcn;
            end

            op_jmp: begin
                regfile_sr1 = sr1;
                pc_mux_sel  = lc3b_pc_mux_sel_alu;        // sr1 passes the alu
            end

            op_jsr: begin
                regfile_sr1 = sr1;
                if (ir_in[11])
                    pc_mux_sel = lc3b_pc_mux_sel_pcn;
                else
                    pc_mux_sel = lc3b_pc_mux_sel_alu;     // jsrr
                pc_adder_mux_sel     = lc3b_pc_adder_mux_sel_offset11;
                regfile_data_mux_sel = lc3b_regfile_data_mux_sel_pc;
                regfile_dest_mux_sel = lc3b_regfile_dest_mux_sel_r7;
                regfile_load         = 1'b1;
            end

            default: begin
                // memory, trap, rti: leave the all-zero word
            end
        endcase
    end

endmodule

`default_nettype wire

// File: decode/decode_stage.sv
`default_nettype none

module decode_stage (
    input  wire                                    clk,
    input  wire                                    rst,
    input  wire                                    instr_valid,
    input  wire lc3b_pkg::lc3b_word                instr,
    input  wire lc3b_pkg::lc3b_word                pc,
    input  wire                                    redirect,
    output lc3b_pkg::lc3b_reg                      sr1_addr,
    output lc3b_pkg::lc3b_reg                      sr2_addr,
    input  wire lc3b_pkg::lc3b_word                sr1_data,
    input  wire lc3b_pkg::lc3b_word                sr2_data,
    output logic                                   ex_valid,
    output lc3b_pkg::lc3b_alu_mux_sel              ex_alu_mux_sel,
    output lc3b_pkg::lc3b_alu_op                   ex_alu_op,
    output lc3b_pkg::lc3b_pc_mux_sel               ex_pc_mux_sel,
    output lc3b_pkg::lc3b_pc_adder_mux_sel         ex_pc_adder_mux_sel,
    output logic                                   ex_conditional_branch,
    output logic                                   ex_cc_load,
    output lc3b_pkg::lc3b_cc_gen_mux_sel           ex_cc_gen_mux_sel,
    output lc3b_pkg::lc3b_regfile_data_mux_sel     ex_regfile_data_mux_sel,
    output lc3b_pkg::lc3b_regfile_dest_mux_sel     ex_regfile_dest_mux_sel,
    output logic                                   ex_regfile_load,
    output lc3b_pkg::lc3b_word                     ex_sr1,
    output lc3b_pkg::lc3b_word                     ex_sr2,
    output lc3b_pkg::lc3b_reg                      ex_dest,
    output lc3b_pkg::lc3b_word                     ex_imm5,
    output lc3b_pkg::lc3b_imm4                     ex_imm4,
    output lc3b_pkg::lc3b_word                     ex_offset9,
    output lc3b_pkg::lc3b_word                     ex_offset11,
    output lc3b_pkg::lc3b_nzp                      ex_nzp,
    output lc3b_pkg::lc3b_word                     ex_pc_next
);
    import lc3b_pkg::*;

    lc3b_alu_mux_sel          alu_mux_sel;
    lc3b_alu_op               alu_op;
    lc3b_pc_mux_sel           pc_mux_sel;
    lc3b_pc_adder_mux_sel     pc_adder_mux_sel;
    logic                     conditional_branch;
    logic                     cc_load;
    lc3b_cc_gen_mux_sel       cc_gen_mux_sel;
    lc3b_regfile_data_mux_sel regfile_data_mux_sel;
    lc3b_regfile_dest_mux_sel regfile_dest_mux_sel;
    logic                     regfile_load;
    logic                     take;

    control_rom rom (
        .ir_in                (instr),
        .regfile_sr1          (sr1_addr),
        .regfile_sr2          (sr2_addr),
        .alu_mux_sel          (alu_mux_sel),
        .alu_op               (alu_op),
        .pc_mux_sel           (pc_mux_sel),
        .pc_adder_mux_sel     (pc_adder_mux_sel),
        .conditional_branch   (conditional_branch),
        .cc_load              (cc_load),
        .cc_gen_mux_sel       (cc_gen_mux_sel),
        .regfile_data_mux_sel (regfile_data_mux_sel),
        .regfile_dest_mux_sel (regfile_dest_mux_sel),
        .regfile_load         (regfile_load)
    );

    assign take = instr_valid && !redirect;     // wrong-path slot is dropped

    always_ff @(posedge clk) begin
        if (rst || !take) begin
            ex_valid                <= 1'b0;
            ex_alu_mux_sel          <= lc3b_alu_mux_sel_sr2;
            ex_alu_op               <= lc3b_alu_op_pass;
            ex_pc_mux_sel           <= lc3b_pc_mux_sel_pc_plus2;
            ex_pc_adder_mux_sel     <= lc3b_pc_adder_mux_sel_offset9;
            ex_conditional_branch   <= 1'b0;
            ex_cc_load              <= 1'b0;
            ex_cc_gen_mux_sel       <= lc3b_cc_gen_mux_sel_alu;
            ex_regfile_data_mux_sel <= lc3b_regfile_data_mux_sel_alu;
            ex_regfile_dest_mux_sel <= lc3b_regfile_dest_mux_sel_dest;
            ex_regfile_load         <= 1'b0;
        end else begin
            ex_valid                <= 1'b1;
            ex_alu_mux_sel          <= alu_mux_sel;
            ex_alu_op               <= alu_op;
            ex_pc_mux_sel           <= pc_mux_sel;
            ex_pc_adder_mux_sel     <= pc_adder_mux_sel;
            ex_conditional_branch   <= conditional_branch;
            ex_cc_load              <= cc_load;
            ex_cc_gen_mux_sel       <= cc_gen_mux_sel;
            ex_regfile_data_mux_sel <= regfile_data_mux_sel;
            ex_regfile_dest_mux_sel <= regfile_dest_mux_sel;
            ex_regfile_load         <= regfile_load;
        end
    end

    always_ff @(posedge clk) begin
        ex_sr1      <= sr1_data;                        // already bypassed
        ex_sr2      <= sr2_data;
        ex_dest     <= instr[11:9];
        ex_nzp      <= instr[11:9];
        ex_imm5     <= {{11{instr[4]}}, instr[4:0]};
        ex_imm4     <= instr[3:0];
        ex_offset9  <= {{7{instr[8]}}, instr[8:0]};
        ex_offset11 <= {{5{instr[10]}}, instr[10:0]};
        ex_pc_next  <= pc + 16'd2;
    end

endmodule

`default_nettype wire

// File: execute/execute_stage.sv
`default_nettype none

module execute_stage (
    input  wire                                    clk,
    input  wire                                    rst,
    input  wire                                    ex_valid,
    input  wire lc3b_pkg::lc3b_alu_mux_sel         ex_alu_mux_sel,
    input  wire lc3b_pkg::lc3b_alu_op              ex_alu_op,
    input  wire lc3b_pkg::lc3b_pc_mux_sel          ex_pc_mux_sel,
    input  wire lc3b_pkg::lc3b_pc_adder_mux_sel    ex_pc_adder_mux_sel,
    input  wire                                    ex_conditional_branch,
    input  wire                                    ex_cc_load,
    input  wire lc3b_pkg::lc3b_cc_gen_mux_sel      ex_cc_gen_mux_sel,
    input  wire lc3b_pkg::lc3b_regfile_data_mux_sel ex_regfile_data_mux_sel,
    input  wire lc3b_pkg::lc3b_regfile_dest_mux_sel ex_regfile_dest_mux_sel,
    input  wire                                    ex_regfile_load,
    input  wire lc3b_pkg::lc3b_word                ex_sr1,
    input  wire lc3b_pkg::lc3b_word                ex_sr2,
    input  wire lc3b_pkg::lc3b_reg                 ex_dest,
    input  wire lc3b_pkg::lc3b_word                ex_imm5,
    input  wire lc3b_pkg::lc3b_imm4                ex_imm4,
    input  wire lc3b_pkg::lc3b_word                ex_offset9,
    input  wire lc3b_pkg::lc3b_word                ex_offset11,
    input  wire lc3b_pkg::lc3b_nzp                 ex_nzp,
    input  wire lc3b_pkg::lc3b_word                ex_pc_next,
    output logic                                   wb_valid,
    output lc3b_pkg::lc3b_reg                      wb_dest,
    output lc3b_pkg::lc3b_word                     wb_data,
    output lc3b_pkg::lc3b_nzp                      cc,
    output logic                                   redirect,
    output lc3b_pkg::lc3b_word                     redirect_target
);
    import lc3b_pkg::*;

    lc3b_word alu_b;
    lc3b_word alu_result;
    lc3b_word offset;
    lc3b_word pcn;
    lc3b_word cc_src;
    logic     taken;

    always_comb begin
        case (ex_alu_mux_sel)
            lc3b_alu_mux_sel_imm5: alu_b = ex_imm5;
            lc3b_alu_mux_sel_imm4: alu_b = {12'd0, ex_imm4};
            default:               alu_b = ex_sr2;
        endcase
    end

    alu alu_i (
        .op     (ex_alu_op),
        .a      (ex_sr1),
        .b      (alu_b),
        .result (alu_result)
    );

    assign offset = (ex_pc_adder_mux_sel == lc3b_pc_adder_mux_sel_offset11) ?
                    ex_offset11 : ex_offset9;
    assign pcn    = ex_pc_next + {offset[14:0], 1'b0};  // word-scaled offset

    always_comb begin
        case (ex_regfile_data_mux_sel)
            lc3b_regfile_data_mux_sel_pcn: wb_data = pcn;
            lc3b_regfile_data_mux_sel_pc:  wb_data = ex_pc_next;  // link
            default:                       wb_data = alu_result;
        endcase
    end

    assign wb_valid = ex_valid && ex_regfile_load;
    assign wb_dest  = (ex_regfile_dest_mux_sel == lc3b_regfile_dest_mux_sel_r7) ?
                      link_reg : ex_dest;

    assign cc_src = (ex_cc_gen_mux_sel == lc3b_cc_gen_mux_sel_pcn) ? pcn : alu_result;

    always_ff @(posedge clk) begin
        if (rst)
            cc <= 3'b000;
        else if (ex_valid && ex_cc_load)
            cc <= {cc_src[15], cc_src == 16'd0, !cc_src[15] && cc_src != 16'd0};
    end

    // cc already holds the previous instruction's result
    assign taken    = !ex_conditional_branch || (ex_nzp & cc) != 3'b000;
    assign redirect = ex_valid && ex_pc_mux_sel != lc3b_pc_mux_sel_pc_plus2 && taken;
    assign redirect_target = (ex_pc_mux_sel == lc3b_pc_mux_sel_alu) ? alu_result : pcn;

endmodule

`default_nettype wire

// File: rtl/regfile.sv
`default_nettype none

module regfile (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     load,
    input  wire lc3b_pkg::lc3b_reg  dest,
    input  wire lc3b_pkg::lc3b_word data,
    input  wire lc3b_pkg::lc3b_reg  sr1,
    input  wire lc3b_pkg::lc3b_reg  sr2,
    output lc3b_pkg::lc3b_word      sr1_out,
    output lc3b_pkg::lc3b_word      sr2_out
);
    import lc3b_pkg::*;

    lc3b_word regs [8];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= 16'h0000;
        end else if (load) begin
            regs[dest] <= data;
        end
    end

    // same-cycle write shows through to decode
    assign sr1_out = (load && dest == sr1) ? data : regs[sr1];
    assign sr2_out = (load && dest == sr2) ? data : regs[sr2];

endmodule

`default_nettype wire

// File: rtl/lc3b_core.sv
`default_nettype none

module lc3b_core (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     instr_valid,
    input  wire lc3b_pkg::lc3b_word instr,
    output lc3b_pkg::lc3b_word      pc,
    output logic                    wb_valid,
    output lc3b_pkg::lc3b_reg       wb_dest,
    output lc3b_pkg::lc3b_word      wb_data,
    output lc3b_pkg::lc3b_nzp       cc
);
    import lc3b_pkg::*;

    lc3b_reg                  sr1_addr;
    lc3b_reg                  sr2_addr;
    lc3b_word                 sr1_data;
    lc3b_word                 sr2_data;
    logic                     redirect;
    lc3b_word                 redirect_target;

    // id/ex register
    logic                     ex_valid;
    lc3b_alu_mux_sel          ex_alu_mux_sel;
    lc3b_alu_op               ex_alu_op;
    lc3b_pc_mux_sel           ex_pc_mux_sel;
    lc3b_pc_adder_mux_sel     ex_pc_adder_mux_sel;
    logic                     ex_conditional_branch;
    logic                     ex_cc_load;
    lc3b_cc_gen_mux_sel       ex_cc_gen_mux_sel;
    lc3b_regfile_data_mux_sel ex_regfile_data_mux_sel;
    lc3b_regfile_dest_mux_sel ex_regfile_dest_mux_sel;
    logic                     ex_regfile_load;
    lc3b_word                 ex_sr1;
    lc3b_word                 ex_sr2;
    lc3b_reg                  ex_dest;
    lc3b_word                 ex_imm5;
    lc3b_imm4                 ex_imm4;
    lc3b_word                 ex_offset9;
    lc3b_word                 ex_offset11;
    lc3b_nzp                  ex_nzp;
    lc3b_word                 ex_pc_next;

    always_ff @(posedge clk) begin
        if (rst)
            pc <= reset_pc;
        else if (redirect)
            pc <= redirect_target;          // wins over the sequential step
        else if (instr_valid)
            pc <= pc + 16'd2;
    end

    decode_stage decode (.*);

    regfile rf (
        .clk     (clk),
        .rst     (rst),
        .load    (wb_valid),
        .dest    (wb_dest),
        .data    (wb_data),
        .sr1     (sr1_addr),
        .sr2     (sr2_addr),
        .sr1_out (sr1_data),
        .sr2_out (sr2_data)
    );

    execute_stage execute (.*);

endmodule

`default_nettype wire

// File: sim/tb_lc3b_core.sv
`default_nettype none

module tb_lc3b_core;
    import lc3b_pkg::*;

    localparam int cycle_budget  = 64;
    localparam int test_count    = 6;
    localparam int watchdog_time = test_count * (cycle_budget + 8) * 10;

    logic     clk;
    logic     rst;
    logic     instr_valid;
    lc3b_word instr;
    lc3b_word pc;
    logic     wb_valid;
    lc3b_reg  wb_dest;
    lc3b_word wb_data;
    lc3b_nzp  cc;

    lc3b_word imem [64];
    lc3b_word prog [$];
    lc3b_word mregs [8];        // architectural model state
    lc3b_nzp  mcc;
    lc3b_word mpc;
    lc3b_reg  exp_dest [$];
    lc3b_word exp_data [$];
    lc3b_nzp  exp_cc [$];
    lc3b_word exp_pc [$];       // fetch order, wrong-path slots included
    integer   seed = 32'h9bfe;
    int       errors = 0;
    int       checks = 0;

    lc3b_core UUT (.*);

    always #5 clk = ~clk;

    initial begin
        #(watchdog_time);
        $display("watchdog expired before the tests completed");
        $display("Simulation FAILED");
        $finish;
    end

    task automatic check_word(input string name, input lc3b_word got, input lc3b_word exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_reg(input string name, input lc3b_reg got, input lc3b_reg exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_nzp(input string name, input lc3b_nzp got, input lc3b_nzp exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    function automatic lc3b_word reg_form(input lc3b_opcode op, input lc3b_reg dr,
                                          input lc3b_reg sr1, input lc3b_reg sr2);
        return {op, dr, sr1, 3'b000, sr2};
    endfunction

    function automatic lc3b_word imm_form(input lc3b_opcode op, input lc3b_reg dr,
                                          input lc3b_reg sr1, input logic [4:0] imm5);
        return {op, dr, sr1, 1'b1, imm5};
    endfunction

    // mode is {ir[5], ir[4]}
    function automatic lc3b_word shift_form(input lc3b_reg dr, input lc3b_reg sr,
                                            input logic [1:0] mode, input lc3b_imm4 amt);
        return {op_shf, dr, sr, mode, amt};
    endfunction

    function automatic lc3b_nzp nzp_of(input lc3b_word v);
        if ($signed(v) < 0)
            return 3'b100;
        if (v == 16'h0000)
            return 3'b010;
        return 3'b001;
    endfunction

    // executes one instruction in program order
    task automatic model_step(input lc3b_word end_pc);
        lc3b_word ir;
        lc3b_word pcn;
        lc3b_word a;
        lc3b_word b;
        lc3b_word res;
        lc3b_word target;
        lc3b_reg  dest;
        logic     writes;
        logic     sets_cc;
        logic     redirects;
        ir        = imem[mpc[6:1]];
        pcn       = mpc + 16'd2;
        a         = mregs[ir[8:6]];
        b         = ir[5] ? {{11{ir[4]}}, ir[4:0]} : mregs[ir[2:0]];
        dest      = ir[11:9];
        target    = pcn;
        writes    = 1'b1;
        sets_cc   = 1'b1;
        redirects = 1'b0;
        res       = 16'h0000;
        exp_pc.push_back(mpc);
        case (lc3b_opcode'(ir[15:12]))
            op_add: res = a + b;
            op_and: res = a & b;
            op_not: res = ~a;
            op_shf: begin
                if (!ir[4])
                    res = a << ir[3:0];
                else if (!ir[5])
                    res = a >> ir[3:0];
                else
                    res = $signed(a) >>> ir[3:0];
            end
            op_lea: res = pcn + ({{7{ir[8]}}, ir[8:0]} << 1);
            op_br: begin
                writes = 1'b0;
                if ((ir[11:9] & mcc) != 3'b000) begin
                    target    = pcn + ({{7{ir[8]}}, ir[8:0]} << 1);
                    redirects = 1'b1;
                end
            end
            op_jmp: begin
                writes    = 1'b0;
                target    = a;
                redirects = 1'b1;
            end
            op_jsr: begin
                target    = ir[11] ? pcn + ({{5{ir[10]}}, ir[10:0]} << 1) : a;
                res       = pcn;
                dest      = link_reg;
                sets_cc   = 1'b0;
                redirects = 1'b1;
            end
            default: writes = 1'b0;         // memory, trap, rti
        endcase
        if (writes) begin
            mregs[dest] = res;
            if (sets_cc)
                mcc = nzp_of(res);
            exp_dest.push_back(dest);
            exp_data.push_back(res);
            exp_cc.push_back(mcc);
        end
        if (redirects && pcn != end_pc)
            exp_pc.push_back(pcn);          // slot fetched before the redirect lands
        mpc = target;
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #1;
        rst         = 1'b1;
        instr_valid = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic run_program();
        lc3b_word end_pc;
        lc3b_nzp  cc_expect;
        logic     cc_pending;
        int       steps;
        int       cycles;
        int       drain;
        for (int i = 0; i < 64; i++)
            imem[i] = (i < prog.size()) ? prog[i] : {op_ldb, 6'd0, 6'(i)};  // no-op fill
        end_pc = lc3b_word'(2 * prog.size());
        for (int i = 0; i < 8; i++)
            mregs[i] = 16'h0000;
        mcc = 3'b000;
        mpc = reset_pc;
        exp_dest.delete();
        exp_data.delete();
        exp_cc.delete();
        exp_pc.delete();
        steps = 0;
        while (mpc != end_pc && steps < cycle_budget) begin
            model_step(end_pc);
            steps++;
        end
        if (mpc != end_pc) begin
            errors++;
            $display("reference model did not reach the end of the program");
        end
        reset_dut();
        cycles     = 0;
        drain      = 0;
        cc_pending = 1'b0;
        while (drain < 2 && cycles < cycle_budget) begin
            if (pc != end_pc) begin
                if (exp_pc.size() == 0) begin
                    errors++;
                    $display("fetch at %h lies beyond the modelled fetch order", pc);
                end else begin
                    check_word("pc", pc, exp_pc.pop_front());
                end
            end
            if (pc == end_pc)
                drain++;                    // let the last instruction retire
            instr_valid = (pc != end_pc);
            instr       = imem[pc[6:1]];
            @(negedge clk);
            if (cc_pending) begin
                check_nzp("cc", cc, cc_expect);
                cc_pending = 1'b0;
            end
            if (wb_valid) begin
                if (exp_dest.size() == 0) begin
                    errors++;
                    $display("unexpected writeback of %h to r%0d", wb_data, wb_dest);
                end else begin
                    check_reg("wb_dest", wb_dest, exp_dest.pop_front());
                    check_word("wb_data", wb_data, exp_data.pop_front());
                    cc_expect  = exp_cc.pop_front();
                    cc_pending = 1'b1;
                end
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        if (drain < 2) begin
            errors++;
            $display("program did not reach its end address within the cycle budget");
        end
        check_word("pc", pc, end_pc);
        check_nzp("cc", cc, mcc);
        if (exp_dest.size() != 0) begin
            errors++;
            $display("%0d expected writebacks never appeared", exp_dest.size());
        end
        if (exp_pc.size() != 0) begin
            errors++;
            $display("%0d expected fetches never happened", exp_pc.size());
        end
    endtask

    task automatic test_reset();
        reset_dut();
        check_word("pc", pc, reset_pc);
        check_nzp("cc", cc, 3'b000);
        repeat (3) begin
            @(negedge clk);
            if (wb_valid !== 1'b0) begin
                errors++;
                $display("[FAIL] wb_valid: got %h, expected %h", wb_valid, 1'b0);
            end
            @(posedge clk);
            #1;
        end
        check_word("pc", pc, reset_pc);     // no valid instruction, pc holds
    endtask

    task automatic test_alu_ops();
        prog.delete();
        prog.push_back(imm_form(op_add, 3'd1, 3'd0, 5'd7));
        prog.push_back(imm_form(op_add, 3'd2, 3'd1, 5'h1d));     // -3, uses r1 at once
        prog.push_back(reg_form(op_add, 3'd3, 3'd1, 3'd2));
        prog.push_back(imm_form(op_and, 3'd4, 3'd3, 5'd5));
        prog.push_back(reg_form(op_and, 3'd5, 3'd3, 3'd1));
        prog.push_back({op_not, 3'd6, 3'd5, 6'h3f});
        prog.push_back(imm_form(op_add, 3'd7, 3'd6, 5'd4));      // zero result
        prog.push_back(imm_form(op_and, 3'd1, 3'd1, 5'd0));
        run_program();
    endtask

    task automatic test_shifts();
        logic [31:0] rnd;
        prog.delete();
        repeat (3) begin
            rnd = $random(seed);
            prog.push_back(imm_form(op_add, 3'd1, 3'd0, rnd[4:0]));
            prog.push_back(shift_form(3'd1, 3'd1, 2'b00, rnd[8:5]));
            prog.push_back(imm_form(op_add, 3'd1, 3'd1, rnd[13:9]));
            prog.push_back(shift_form(3'd2, 3'd1, 2'b00, rnd[17:14]));
            prog.push_back(shift_form(3'd3, 3'd1, 2'b01, rnd[21:18]));
            prog.push_back(shift_form(3'd4, 3'd1, 2'b11, rnd[25:22]));
            prog.push_back({op_not, 3'd5, 3'd1, 6'h3f});         // opposite sign of r1
            prog.push_back(shift_form(3'd6, 3'd5, 2'b01, rnd[21:18]));
            prog.push_back(shift_form(3'd7, 3'd5, 2'b11, rnd[25:22]));
        end
        run_program();
    endtask

    task automatic test_lea();
        prog.delete();
        prog.push_back({op_lea, 3'd1, 9'd5});
        prog.push_back({op_lea, 3'd2, 9'h1fc});                  // lands below zero
        prog.push_back({op_lea, 3'd3, 9'd0});
        prog.push_back({op_lea, 3'd4, 9'h1fc});                  // lands on zero
        prog.push_back(reg_form(op_add, 3'd5, 3'd4, 3'd1));
        run_program();
    endtask

    task automatic test_branches();
        prog.delete();
        prog.push_back(imm_form(op_add, 3'd1, 3'd0, 5'h1f));
        prog.push_back({op_br, 3'b100, 9'd1});                   // taken
        prog.push_back(imm_form(op_add, 3'd2, 3'd0, 5'd1));      // wrong path
        prog.push_back({op_br, 3'b010, 9'd1});                   // not taken
        prog.push_back(imm_form(op_add, 3'd3, 3'd0, 5'd2));
        prog.push_back({op_br, 3'b011, 9'd1});
        prog.push_back(imm_form(op_add, 3'd4, 3'd0, 5'd3));
        prog.push_back(imm_form(op_and, 3'd5, 3'd0, 5'd0));
        prog.push_back({op_br, 3'b101, 9'd1});
        prog.push_back(imm_form(op_add, 3'd6, 3'd0, 5'd5));
        prog.push_back({op_br, 3'b111, 9'd1});
        prog.push_back(imm_form(op_add, 3'd7, 3'd0, 5'd7));
        prog.push_back({op_br, 3'b000, 9'd1});                   // empty mask
        prog.push_back(imm_form(op_add, 3'd1, 3'd1, 5'd1));
        run_program();
    endtask

    task automatic test_jumps();
        prog.delete();
        prog.push_back({op_lea, 3'd1, 9'd2});
        prog.push_back({op_jmp, 3'b000, 3'd1, 6'd0});
        prog.push_back(imm_form(op_add, 3'd2, 3'd0, 5'd1));
        prog.push_back({op_jsr, 1'b1, 11'd2});
        prog.push_back(imm_form(op_add, 3'd3, 3'd0, 5'd3));
        prog.push_back(imm_form(op_add, 3'd4, 3'd0, 5'd4));
        prog.push_back({op_lea, 3'd5, 9'd2});
        prog.push_back({op_jsr, 3'b000, 3'd5, 6'd0});            // register form
        prog.push_back(imm_form(op_add, 3'd6, 3'd0, 5'd6));
        prog.push_back({op_ldb, 12'h123});
        prog.push_back({op_str, 12'h2c5});
        prog.push_back({op_trap, 12'h025});
        prog.push_back({op_rti, 12'h000});
        prog.push_back(imm_form(op_add, 3'd6, 3'd7, 5'd0));      // reads the link value
        run_program();
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = 16'h0000;
        test_reset();
        test_alu_ops();
        test_shifts();
        test_lea();
        test_branches();
        test_jumps();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
common/lc3b_pkg.sv
execute/alu.sv
decode/control_rom.sv
decode/decode_stage.sv
execute/execute_stage.sv
rtl/regfile.sv
rtl/lc3b_core.sv
sim/tb_lc3b_core.sv
